/* design/bus_port_merge.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_port_merge
    import cache_bus_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  wire         rd_busy_i,
    input  wire         wr_busy_i,
    input  wire addr_t  pend_addr_i,
    input  wire addr_t  wr_line_addr_i,
    output logic        read_hold_o,
    output logic        bus_ce_o,
    output strb_t       wstrb_o,
    output len_t        rlen_o,
    output len_t        wlen_o,
    output logic        rd_ready_o,
    output logic        wr_ready_o
);

    logic ce_q;
    logic same_line;

    // only the line bits matter, the offset is already cleared
    assign same_line = pend_addr_i[31:OFFSET_BITS] == wr_line_addr_i[31:OFFSET_BITS];

    // refill of a line still being written back would fetch stale words
    assign read_hold_o = wr_busy_i && same_line;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            ce_q <= 1'b0;
        else
            ce_q <= 1'b1;
    end

    assign bus_ce_o = ce_q;

    // full word writes only
    assign wstrb_o = wr_busy_i ? '1 : '0;

    assign rlen_o = BURST_LEN;
    assign wlen_o = BURST_LEN;

    assign rd_ready_o = !rd_busy_i;
    assign wr_ready_o = !wr_busy_i;

endmodule

`default_nettype wire

/* design/cache_bus_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_bus_bridge
    import cache_bus_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire rd_req_t    icache_req_i,
    input  wire rd_req_t    dcache_req_i,
    input  wire wr_req_t    wr_req_i,
    input  wire word_t      rdata_i,
    input  wire             rdata_valid_i,
    input  wire             wresp_i,
    output rd_bus_t         rd_bus_o,
    output wr_bus_t         wr_bus_o,
    output logic            bus_ce_o,
    output strb_t           wstrb_o,
    output len_t            rlen_o,
    output len_t            wlen_o,
    output logic            rd_ready_o,
    output logic            wr_ready_o,
    output line_t           icache_line_o,
    output logic            icache_valid_o,
    output line_t           dcache_line_o,
    output logic            dcache_valid_o,
    output logic            wr_done_o
);

    logic  rd_busy;
    logic  wr_busy;
    logic  read_hold;
    addr_t pend_addr;
    addr_t wr_line_addr;

    refill_read_engine i_read (
        .clk            (clk),
        .rst            (rst),
        .icache_req_i   (icache_req_i),
        .dcache_req_i   (dcache_req_i),
        .read_hold_i    (read_hold),
        .rdata_i        (rdata_i),
        .rdata_valid_i  (rdata_valid_i),
        .rd_bus_o       (rd_bus_o),
        .pend_addr_o    (pend_addr),
        .busy_o         (rd_busy),
        .icache_line_o  (icache_line_o),
        .icache_valid_o (icache_valid_o),
        .dcache_line_o  (dcache_line_o),
        .dcache_valid_o (dcache_valid_o)
    );

    writeback_engine i_write (
        .clk            (clk),
        .rst            (rst),
        .wr_req_i       (wr_req_i),
        .wresp_i        (wresp_i),
        .wr_bus_o       (wr_bus_o),
        .wr_line_addr_o (wr_line_addr),
        .busy_o         (wr_busy),
        .wr_done_o      (wr_done_o)
    );

    bus_port_merge i_merge (
        .clk            (clk),
        .rst            (rst),
        .rd_busy_i      (rd_busy),
        .wr_busy_i      (wr_busy),
        .pend_addr_i    (pend_addr),
        .wr_line_addr_i (wr_line_addr),
        .read_hold_o    (read_hold),
        .bus_ce_o       (bus_ce_o),
        .wstrb_o        (wstrb_o),
        .rlen_o         (rlen_o),
        .wlen_o         (wlen_o),
        .rd_ready_o     (rd_ready_o),
        .wr_ready_o     (wr_ready_o)
    );

endmodule

`default_nettype wire

/* design/cache_bus_pkg.sv */
`default_nettype none

package cache_bus_pkg;

    localparam int WORD_BITS   = 32;
    localparam int LINE_BEATS  = 4;
    localparam int LINE_BITS   = WORD_BITS * LINE_BEATS;
    localparam int OFFSET_BITS = 4;

    typedef logic [31:0]          addr_t;
    typedef logic [WORD_BITS-1:0] word_t;
    typedef logic [LINE_BITS-1:0] line_t;
    typedef logic [1:0]           beat_cnt_t;
    typedef logic [3:0]           strb_t;
    typedef logic [7:0]           len_t;

    // burst length field is beats minus one
    localparam len_t      BURST_LEN = len_t'(LINE_BEATS - 1);
    localparam beat_cnt_t LAST_BEAT = beat_cnt_t'(LINE_BEATS - 1);

    typedef enum logic [1:0] {
        RD_IDLE   = 2'b00,
        RD_ICACHE = 2'b01,
        RD_DCACHE = 2'b10
    } rd_state_t;

    typedef enum logic {
        WR_IDLE = 1'b0,
        WR_BUSY = 1'b1
    } wr_state_t;

    typedef struct packed {
        logic  req;
        addr_t addr;
    } rd_req_t;

    typedef struct packed {
        logic  req;
        addr_t addr;
        line_t line;
    } wr_req_t;

    typedef struct packed {
        logic  en;
        addr_t addr;
    } rd_bus_t;

    typedef struct packed {
        logic  en;
        addr_t addr;
        word_t data;
        logic  last;
    } wr_bus_t;

    // clear the byte offset within a line
    function automatic addr_t line_align(addr_t addr);
        return {addr[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    endfunction

endpackage

`default_nettype wire

/* design/refill_read_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module refill_read_engine
    import cache_bus_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire rd_req_t    icache_req_i,
    input  wire rd_req_t    dcache_req_i,
    input  wire             read_hold_i,
    input  wire word_t      rdata_i,
    input  wire             rdata_valid_i,
    output rd_bus_t         rd_bus_o,
    output addr_t           pend_addr_o,
    output logic            busy_o,
    output line_t           icache_line_o,
    output logic            icache_valid_o,
    output line_t           dcache_line_o,
    output logic            dcache_valid_o
);

    rd_state_t state_q;
    beat_cnt_t beat_q;
    addr_t     addr_q;
    line_t     icache_line_q;
    line_t     dcache_line_q;
    logic      icache_valid_q;
    logic      dcache_valid_q;
    logic      take_d;
    logic      take_i;
    logic      last_beat;

    // a cache still seeing its valid pulse holds the request it just got served
    assign take_d = dcache_req_i.req && !dcache_valid_q;
    assign take_i = icache_req_i.req && !icache_valid_q && !take_d;

    assign last_beat = rdata_valid_i && (beat_q == LAST_BEAT);

    // line the next acceptance would fetch, for the same-line check
    assign pend_addr_o = take_d ? line_align(dcache_req_i.addr)
                                : line_align(icache_req_i.addr);

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state_q <= RD_IDLE;
            addr_q  <= '0;
        end
        else
        begin
            unique case (state_q)
                RD_IDLE:
                begin
                    if (!read_hold_i && take_d)
                    begin
                        state_q <= RD_DCACHE;
                        addr_q  <= line_align(dcache_req_i.addr);
                    end
                    else if (!read_hold_i && take_i)
                    begin
                        state_q <= RD_ICACHE;
                        addr_q  <= line_align(icache_req_i.addr);
                    end
                end
                RD_ICACHE, RD_DCACHE:
                begin
                    if (last_beat)
                        state_q <= RD_IDLE;
                end
                default:
                    state_q <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            beat_q <= '0;
        else if (state_q == RD_IDLE)
            beat_q <= '0;
        else if (rdata_valid_i)
            beat_q <= beat_q + beat_cnt_t'(1);
    end

    // each requester keeps its own line
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            icache_line_q <= '0;
            dcache_line_q <= '0;
        end
        else if (rdata_valid_i)
        begin
            if (state_q == RD_ICACHE)
                icache_line_q[WORD_BITS*beat_q +: WORD_BITS] <= rdata_i;
            if (state_q == RD_DCACHE)
                dcache_line_q[WORD_BITS*beat_q +: WORD_BITS] <= rdata_i;
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            icache_valid_q <= 1'b0;
            dcache_valid_q <= 1'b0;
        end
        else
        begin
            icache_valid_q <= (state_q == RD_ICACHE) && last_beat;
            dcache_valid_q <= (state_q == RD_DCACHE) && last_beat;
        end
    end

    always_comb
    begin
        rd_bus_o.en   = state_q != RD_IDLE;
        rd_bus_o.addr = addr_q;
    end

    assign busy_o         = state_q != RD_IDLE;
    assign icache_line_o  = icache_line_q;
    assign icache_valid_o = icache_valid_q;
    assign dcache_line_o  = dcache_line_q;
    assign dcache_valid_o = dcache_valid_q;

endmodule

`default_nettype wire

/* design/writeback_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module writeback_engine
    import cache_bus_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire wr_req_t    wr_req_i,
    input  wire             wresp_i,
    output wr_bus_t         wr_bus_o,
    output addr_t           wr_line_addr_o,
    output logic            busy_o,
    output logic            wr_done_o
);

    wr_state_t state_q;
    beat_cnt_t beat_q;
    addr_t     addr_q;
    line_t     line_q;
    logic      done_q;
    logic      accept;
    logic      final_resp;

    // request is still held during the done cycle, do not take it twice
    assign accept     = (state_q == WR_IDLE) && wr_req_i.req && !done_q;
    assign final_resp = wresp_i && (beat_q == LAST_BEAT);

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state_q <= WR_IDLE;
            addr_q  <= '0;
        end
        else
        begin
            unique case (state_q)
                WR_IDLE:
                begin
                    if (accept)
                    begin
                        state_q <= WR_BUSY;
                        addr_q  <= line_align(wr_req_i.addr);
                    end
                end
                WR_BUSY:
                begin
                    if (final_resp)
                        state_q <= WR_IDLE;
                end
                default:
                    state_q <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            line_q <= wr_req_i.line;
    end

    // beat advances on each write response
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            beat_q <= '0;
        else if (state_q == WR_IDLE)
            beat_q <= '0;
        else if (wresp_i)
            beat_q <= beat_q + beat_cnt_t'(1);
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            done_q <= 1'b0;
        else
            done_q <= (state_q == WR_BUSY) && final_resp;
    end

    always_comb
    begin
        wr_bus_o.en   = state_q == WR_BUSY;
        wr_bus_o.addr = addr_q;
        wr_bus_o.data = line_q[WORD_BITS*beat_q +: WORD_BITS];
        wr_bus_o.last = (state_q == WR_BUSY) && (beat_q == LAST_BEAT);
    end

    assign wr_line_addr_o = addr_q;
    assign busy_o         = state_q == WR_BUSY;
    assign wr_done_o      = done_q;

endmodule

`default_nettype wire

/* filelist.f */
design/cache_bus_pkg.sv
design/refill_read_engine.sv
design/writeback_engine.sv
design/bus_port_merge.sv
design/cache_bus_bridge.sv
tb/mem_bus_model.sv
tb/tb_cache_bus_bridge.sv

/* tb/mem_bus_model.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_bus_model
    import cache_bus_pkg::*;
#(
    parameter int    DEPTH        = 512,
    parameter word_t FILL_PATTERN = 32'h0,
    parameter int    MAX_GAP      = 3
)
(
    input  wire          clk,
    input  wire rd_bus_t rd_bus_i,
    input  wire wr_bus_t wr_bus_i,
    output word_t        rdata_o,
    output logic         rdata_valid_o,
    output logic         wresp_o
);

    word_t mem [0:DEPTH-1];

    function automatic int word_index(input addr_t addr, input int k);
        return (addr >> 2) + k;
    endfunction

    // idle cycles before the next strobe
    task automatic gap_cycles();
        int n;
        n = $urandom_range(MAX_GAP, 0);
        repeat (n)
        begin
            @(posedge clk);
            #2;
        end
    endtask

    initial
    begin
        for (int i = 0; i < DEPTH; i++)
            mem[i] = word_t'(i * 4) ^ FILL_PATTERN;
    end

    // read channel, one burst at a time
    initial
    begin
        rdata_o       = '0;
        rdata_valid_o = 1'b0;
        forever
        begin
            @(posedge clk);
            #2;
            if (rd_bus_i.en)
            begin
                for (int k = 0; k < LINE_BEATS; k++)
                begin
                    gap_cycles();
                    rdata_o       = mem[word_index(rd_bus_i.addr, k)];
                    rdata_valid_o = 1'b1;
                    @(posedge clk);
                    #2;
                    rdata_valid_o = 1'b0;
                end
            end
        end
    end

    // write channel
    initial
    begin
        wresp_o = 1'b0;
        forever
        begin
            @(posedge clk);
            #2;
            if (wr_bus_i.en)
            begin
                for (int k = 0; k < LINE_BEATS; k++)
                begin
                    gap_cycles();
                    mem[word_index(wr_bus_i.addr, k)] = wr_bus_i.data;
                    wresp_o = 1'b1;
                    @(posedge clk);
                    #2;
                    wresp_o = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tb/tb_cache_bus_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cache_bus_bridge
    import cache_bus_pkg::*;
();

    localparam int    CLK_PERIOD   = 40;
    localparam int    RESET_CYCLES = 16;
    localparam int    MAX_GAP      = 3;
    localparam int    REQ_COUNT    = 40;
    localparam int    DEPTH        = 512;
    localparam word_t FILL         = 32'h5a3c_96e1;
    // a beat costs at most the gap plus its strobe cycle
    localparam int    WATCHDOG_CYCLES = REQ_COUNT * LINE_BEATS * (MAX_GAP + 1) * 2;
    localparam int    OP_LIMIT        = 2 * LINE_BEATS * (MAX_GAP + 1) + 8;

    logic    clk;
    logic    rst;
    rd_req_t icache_req_i;
    rd_req_t dcache_req_i;
    wr_req_t wr_req_i;
    word_t   rdata_i;
    logic    rdata_valid_i;
    logic    wresp_i;
    rd_bus_t rd_bus_o;
    wr_bus_t wr_bus_o;
    logic    bus_ce_o;
    strb_t   wstrb_o;
    len_t    rlen_o;
    len_t    wlen_o;
    logic    rd_ready_o;
    logic    wr_ready_o;
    line_t   icache_line_o;
    line_t   dcache_line_o;
    logic    icache_valid_o;
    logic    dcache_valid_o;
    logic    wr_done_o;

    word_t ref_mem [0:DEPTH-1];
    line_t wb_line;
    int    wb_beat;
    int    cycle_no;
    int    icache_pulses;
    int    dcache_pulses;
    int    done_pulses;
    bit    overlap_seen;

    cache_bus_bridge i_dut (.*);

    mem_bus_model #(
        .DEPTH        (DEPTH),
        .FILL_PATTERN (FILL),
        .MAX_GAP      (MAX_GAP)
    ) i_mem (
        .clk           (clk),
        .rd_bus_i      (rd_bus_o),
        .wr_bus_i      (wr_bus_o),
        .rdata_o       (rdata_i),
        .rdata_valid_o (rdata_valid_i),
        .wresp_o       (wresp_i)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input line_t exp, input line_t act);
        assert (act === exp)
        else
            abort_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    function automatic int word_index(input addr_t addr, input int k);
        return ((addr & ~32'hf) >> 2) + k;
    endfunction

    function automatic line_t expected_line(input addr_t addr);
        line_t l;
        for (int k = 0; k < LINE_BEATS; k++)
            l[32*k +: 32] = ref_mem[word_index(addr, k)];
        return l;
    endfunction

    function automatic line_t random_line();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    task automatic refill(input bit dside, input addr_t addr, input string name,
                          output int done_cycle);
        line_t exp;
        int    n;
        exp = expected_line(addr);
        if (dside)
            dcache_req_i = {1'b1, addr};
        else
            icache_req_i = {1'b1, addr};
        n = 0;
        do
        begin
            tick();
            n++;
            if (n > OP_LIMIT)
                abort_run($sformatf("%s: refill valid never arrived", name));
        end
        while (!(dside ? dcache_valid_o : icache_valid_o));
        check_value(name, exp, dside ? dcache_line_o : icache_line_o);
        done_cycle = cycle_no;
        if (dside)
            dcache_req_i.req = 1'b0;
        else
            icache_req_i.req = 1'b0;
        tick();
        assert (!(dside ? dcache_valid_o : icache_valid_o))
        else
            abort_run($sformatf("%s: refill valid longer than one cycle", name));
    endtask

    task automatic writeback(input addr_t addr, input line_t line, input string name);
        int n;
        for (int k = 0; k < LINE_BEATS; k++)
            ref_mem[word_index(addr, k)] = line[32*k +: 32];
        wr_req_i = {1'b1, addr, line};
        wb_line  = line;
        wb_beat  = 0;
        n = 0;
        do
        begin
            tick();
            n++;
            if (n > OP_LIMIT)
                abort_run($sformatf("%s: write done never arrived", name));
        end
        while (!wr_done_o);
        check_value({name, " beats"}, LINE_BEATS, wb_beat);
        wr_req_i.req = 1'b0;
        tick();
        assert (!wr_done_o)
        else
            abort_run($sformatf("%s: write done longer than one cycle", name));
    endtask

    task automatic wait_write_busy();
        do
            tick();
        while (wr_ready_o);
    endtask

    // bus monitor, sampled half a cycle away from the drive point
    always @(negedge clk)
    begin
        cycle_no++;
        if (icache_valid_o)
            icache_pulses++;
        if (dcache_valid_o)
            dcache_pulses++;
        if (wr_done_o)
            done_pulses++;
        if (!rd_ready_o && !wr_ready_o)
            overlap_seen = 1'b1;
        if (rd_bus_o.en)
            assert (rd_bus_o.addr[3:0] == 4'h0)
            else
                abort_run("read burst address is not line aligned");
        if (wresp_i)
        begin
            check_value("write beat data", wb_line[32*wb_beat +: 32], wr_bus_o.data);
            check_value("write beat last", wb_beat == LINE_BEATS - 1, wr_bus_o.last);
            check_value("write strobe", 4'hf, wstrb_o);
            wb_beat++;
        end
    end

    initial
    begin
        repeat (RESET_CYCLES + WATCHDOG_CYCLES) @(posedge clk);
        abort_run("watchdog expired before the tests finished");
    end

    initial
    begin
        int    t_d;
        int    t_i;
        int    op;
        addr_t a;
        line_t data;
        void'($urandom(46));
        rst           = 1'b0;
        icache_req_i  = '0;
        dcache_req_i  = '0;
        wr_req_i      = '0;
        wb_line       = '0;
        wb_beat       = 0;
        cycle_no      = 0;
        icache_pulses = 0;
        dcache_pulses = 0;
        done_pulses   = 0;
        overlap_seen  = 1'b0;
        for (int i = 0; i < DEPTH; i++)
            ref_mem[i] = word_t'(i * 4) ^ FILL;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b1;
        tick();

        check_value("reset flags", 8'b0000_0011, {icache_valid_o, dcache_valid_o, wr_done_o,
                    rd_bus_o.en, wr_bus_o.en, wr_bus_o.last, rd_ready_o, wr_ready_o});
        check_value("reset icache line", '0, icache_line_o);
        check_value("reset dcache line", '0, dcache_line_o);
        check_value("port controls", {1'b1, 4'h0, 8'd3, 8'd3}, {bus_ce_o, wstrb_o, rlen_o, wlen_o});

        refill(1'b0, 32'h0000_0048, "icache refill", t_i);
        check_value("icache pulse count", 1, icache_pulses);
        check_value("dcache pulse count", 0, dcache_pulses);

        fork
            refill(1'b1, 32'h0000_0104, "dcache first", t_d);
            refill(1'b0, 32'h0000_0208, "icache second", t_i);
        join
        assert (t_d < t_i)
        else
            abort_run("icache refill finished before the dcache refill");

        writeback(32'h0000_0306, random_line(), "writeback");
        check_value("done pulse count", 1, done_pulses);
        refill(1'b1, 32'h0000_030c, "refill after writeback", t_d);

        // same line must wait for the writeback to finish
        data = random_line();
        overlap_seen = 1'b0;
        fork
            writeback(32'h0000_0400, data, "writeback same line");
            begin
                wait_write_busy();
                refill(1'b1, 32'h0000_0408, "refill under writeback", t_d);
            end
        join
        assert (!overlap_seen)
        else
            abort_run("refill of the line under writeback was not held");

        overlap_seen = 1'b0;
        fork
            writeback(32'h0000_0500, random_line(), "writeback other line");
            begin
                wait_write_busy();
                refill(1'b0, 32'h0000_0600, "refill beside writeback", t_i);
            end
        join
        assert (overlap_seen)
        else
            abort_run("refill of another line did not run during the writeback");

        for (int i = 0; i < 24; i++)
        begin
            a  = 32'h0000_0700 + $urandom_range(127, 0);
            op = $urandom_range(2, 0);
            if (op == 0)
                refill(1'b0, a, "random icache refill", t_i);
            else if (op == 1)
                refill(1'b1, a, "random dcache refill", t_d);
            else
                writeback(a, random_line(), "random writeback");
        end

        tick();
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire
